// ==== files.f ====
rtl/noc_pkg.sv
rtl/vc_input_buffer.sv
rtl/credit_counter.sv
rtl/output_allocator.sv
rtl/mesh_router.sv
rtl/mesh_row.sv
sim/mesh_row_tb.sv

// ==== rtl/credit_counter.sv ====
`timescale 1ns/10ps

module credit_counter #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic [noc_pkg::NUM_VC-1:0] i_send,
    input  logic [noc_pkg::NUM_VC-1:0] i_ack,
    output logic [noc_pkg::NUM_VC-1:0] o_has_credit
);
    import noc_pkg::*;

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(BUF_DEPTH);

    for (genvar v = 0; v < NUM_VC; v++) begin : g_vc
        logic [CNT_W-1:0] count;

        // Send and ack in one cycle cancel out
        always_ff @(posedge i_clk) begin
            if (i_rst) begin
                count <= FULL;
            end else begin
                case ({i_send[v], i_ack[v]})
                    2'b10: if (count != '0) count <= count - 1'b1;
                    2'b01: if (count != FULL) count <= count + 1'b1;
                    default: count <= count;
                endcase
            end
        end

        assign o_has_credit[v] = (count != '0);

        // Allocator never sends without credit
        a_no_negative: assert property (@(posedge i_clk) disable iff (i_rst)
            i_send[v] |-> count != '0);

        // Downstream never returns more credits than it has slots
        a_no_excess: assert property (@(posedge i_clk) disable iff (i_rst)
            (i_ack[v] && !i_send[v]) |-> count != FULL);
    end

endmodule

// ==== rtl/mesh_router.sv ====
`timescale 1ns/10ps

module mesh_router #(
    parameter logic [1:0] MY_X      = 2'd0,
    parameter logic [1:0] MY_Y      = 2'd0,
    parameter int         BUF_DEPTH = 4
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  noc_pkg::flit_t             i_data_west,
    input  logic                       i_valid_west,
    input  logic                       i_vch_west,
    input  logic [noc_pkg::NUM_VC-1:0] i_ack_west,
    input  logic [noc_pkg::NUM_VC-1:0] i_lck_west,
    output noc_pkg::flit_t             o_data_west,
    output logic                       o_valid_west,
    output logic                       o_vch_west,
    output logic [noc_pkg::NUM_VC-1:0] o_ack_west,
    output logic [noc_pkg::NUM_VC-1:0] o_lck_west,
    output logic [noc_pkg::NUM_VC-1:0] o_rdy_west,
    input  noc_pkg::flit_t             i_data_east,
    input  logic                       i_valid_east,
    input  logic                       i_vch_east,
    input  logic [noc_pkg::NUM_VC-1:0] i_ack_east,
    input  logic [noc_pkg::NUM_VC-1:0] i_lck_east,
    output noc_pkg::flit_t             o_data_east,
    output logic                       o_valid_east,
    output logic                       o_vch_east,
    output logic [noc_pkg::NUM_VC-1:0] o_ack_east,
    output logic [noc_pkg::NUM_VC-1:0] o_lck_east,
    output logic [noc_pkg::NUM_VC-1:0] o_rdy_east,
    input  noc_pkg::flit_t             i_data_local,
    input  logic                       i_valid_local,
    input  logic                       i_vch_local,
    input  logic [noc_pkg::NUM_VC-1:0] i_ack_local,
    input  logic [noc_pkg::NUM_VC-1:0] i_lck_local,
    output noc_pkg::flit_t             o_data_local,
    output logic                       o_valid_local,
    output logic                       o_vch_local,
    output logic [noc_pkg::NUM_VC-1:0] o_ack_local,
    output logic [noc_pkg::NUM_VC-1:0] o_lck_local,
    output logic [noc_pkg::NUM_VC-1:0] o_rdy_local
);
    import noc_pkg::*;

    // Flat requester index is port * NUM_VC + vc throughout
    localparam int NUM_REQ = NUM_PORTS * NUM_VC;

    flit_t [NUM_PORTS-1:0]             in_data;
    logic  [NUM_PORTS-1:0]             in_valid;
    logic  [NUM_PORTS-1:0]             in_vch;
    logic  [NUM_PORTS-1:0][NUM_VC-1:0] in_ack;
    logic  [NUM_PORTS-1:0][NUM_VC-1:0] in_lck;
    flit_t [NUM_REQ-1:0]               head_data;
    logic  [NUM_REQ-1:0]               head_valid;
    logic  [NUM_REQ-1:0]               deq;
    logic  [NUM_REQ-1:0]               buf_ack;
    logic  [NUM_REQ-1:0]               buf_rdy;
    logic  [NUM_REQ-1:0]               buf_lck;
    logic  [NUM_REQ-1:0]               req_head;
    logic  [NUM_REQ-1:0]               req_tail;
    logic  [NUM_REQ-1:0]               req   [NUM_PORTS];
    logic  [NUM_REQ-1:0]               grant [NUM_PORTS];
    logic  [1:0]                       route_q   [NUM_REQ];
    logic  [1:0]                       route_now [NUM_REQ];
    flit_t                             out_data  [NUM_PORTS];
    logic                              out_valid [NUM_PORTS];
    logic                              out_vch   [NUM_PORTS];

    function automatic logic [1:0] xroute(logic [1:0] dst_x);
        if (dst_x < MY_X) return 2'(PORT_WEST);
        if (dst_x > MY_X) return 2'(PORT_EAST);
        return 2'(PORT_LOCAL);
    endfunction

    assign in_data  = {i_data_local, i_data_east, i_data_west};
    assign in_valid = {i_valid_local, i_valid_east, i_valid_west};
    assign in_vch   = {i_vch_local, i_vch_east, i_vch_west};
    assign in_ack   = {i_ack_local, i_ack_east, i_ack_west};
    assign in_lck   = {i_lck_local, i_lck_east, i_lck_west};

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        vc_input_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_data       (in_data[p]),
            .i_valid      (in_valid[p]),
            .i_vch        (in_vch[p]),
            .i_deq        (deq[p*NUM_VC +: NUM_VC]),
            .o_head_data  (head_data[p*NUM_VC +: NUM_VC]),
            .o_head_valid (head_valid[p*NUM_VC +: NUM_VC]),
            .o_ack        (buf_ack[p*NUM_VC +: NUM_VC]),
            .o_rdy        (buf_rdy[p*NUM_VC +: NUM_VC]),
            .o_lck        (buf_lck[p*NUM_VC +: NUM_VC])
        );
    end

    // Heads pick their port from dst_x, later flits follow the stored choice
    always_comb begin
        for (int r = 0; r < NUM_REQ; r++) begin
            req_head[r]  = is_head(head_data[r].head.kind);
            req_tail[r]  = is_tail(head_data[r].head.kind);
            route_now[r] = req_head[r] ? xroute(head_data[r].head.dst_x) : route_q[r];
            for (int o = 0; o < NUM_PORTS; o++) begin
                req[o][r] = head_valid[r] && (route_now[r] == 2'(o));
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int r = 0; r < NUM_REQ; r++) begin
            if (i_rst) begin
                route_q[r] <= 2'(PORT_LOCAL);
            end else if (deq[r] && req_head[r]) begin
                route_q[r] <= route_now[r];
            end
        end
    end

    always_comb begin
        deq = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            deq = deq | grant[o];
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        flit_t             xbar_data;
        logic              xbar_vch;
        logic [NUM_VC-1:0] send;
        logic [NUM_VC-1:0] has_credit;

        output_allocator u_alloc (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_req        (req[o]),
            .i_req_head   (req_head),
            .i_req_tail   (req_tail),
            .i_has_credit (has_credit),
            .i_lck        (in_lck[o]),
            .o_grant      (grant[o])
        );

        credit_counter #(.BUF_DEPTH(BUF_DEPTH)) u_credit (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_send       (send),
            .i_ack        (in_ack[o]),
            .o_has_credit (has_credit)
        );

        always_comb begin
            xbar_data = '0;
            xbar_vch  = 1'b0;
            send      = '0;
            for (int r = 0; r < NUM_REQ; r++) begin
                if (grant[o][r]) begin
                    xbar_data          = head_data[r];
                    xbar_vch           = 1'(r % NUM_VC);
                    send[r % NUM_VC]   = 1'b1;
                end
            end
        end

        // Crossbar output register launches the granted flit
        always_ff @(posedge i_clk) begin
            if (i_rst) begin
                out_valid[o] <= 1'b0;
            end else begin
                out_valid[o] <= |grant[o];
            end
        end

        always_ff @(posedge i_clk) begin
            if (|grant[o]) begin
                out_data[o] <= xbar_data;
                out_vch[o]  <= xbar_vch;
            end
        end
    end

    // One-row mesh, so local heads must already sit on our row
    for (genvar r = 0; r < NUM_REQ; r++) begin : g_chk
        a_local_row: assert property (@(posedge i_clk) disable iff (i_rst)
            deq[r] && req_head[r] && route_now[r] == 2'(PORT_LOCAL)
            |-> head_data[r].head.dst_y == MY_Y);
    end

    assign o_data_west   = out_data[PORT_WEST];
    assign o_valid_west  = out_valid[PORT_WEST];
    assign o_vch_west    = out_vch[PORT_WEST];
    assign o_data_east   = out_data[PORT_EAST];
    assign o_valid_east  = out_valid[PORT_EAST];
    assign o_vch_east    = out_vch[PORT_EAST];
    assign o_data_local  = out_data[PORT_LOCAL];
    assign o_valid_local = out_valid[PORT_LOCAL];
    assign o_vch_local   = out_vch[PORT_LOCAL];

    assign {o_ack_local, o_ack_east, o_ack_west} = buf_ack;
    assign {o_rdy_local, o_rdy_east, o_rdy_west} = buf_rdy;
    assign {o_lck_local, o_lck_east, o_lck_west} = buf_lck;

endmodule

// ==== rtl/mesh_row.sv ====
`timescale 1ns/10ps

module mesh_row #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  noc_pkg::flit_t             i_data_0,
    input  logic                       i_valid_0,
    input  logic                       i_vch_0,
    input  logic [noc_pkg::NUM_VC-1:0] i_ack_0,
    input  logic [noc_pkg::NUM_VC-1:0] i_lck_0,
    output noc_pkg::flit_t             o_data_0,
    output logic                       o_valid_0,
    output logic                       o_vch_0,
    output logic [noc_pkg::NUM_VC-1:0] o_ack_0,
    output logic [noc_pkg::NUM_VC-1:0] o_lck_0,
    output logic [noc_pkg::NUM_VC-1:0] o_rdy_0,
    input  noc_pkg::flit_t             i_data_1,
    input  logic                       i_valid_1,
    input  logic                       i_vch_1,
    input  logic [noc_pkg::NUM_VC-1:0] i_ack_1,
    input  logic [noc_pkg::NUM_VC-1:0] i_lck_1,
    output noc_pkg::flit_t             o_data_1,
    output logic                       o_valid_1,
    output logic                       o_vch_1,
    output logic [noc_pkg::NUM_VC-1:0] o_ack_1,
    output logic [noc_pkg::NUM_VC-1:0] o_lck_1,
    output logic [noc_pkg::NUM_VC-1:0] o_rdy_1
);
    import noc_pkg::*;

    // Link from router 0 east to router 1 west
    flit_t             r0_to_r1_data;
    logic              r0_to_r1_valid;
    logic              r0_to_r1_vch;
    logic [NUM_VC-1:0] r0_to_r1_ack;
    logic [NUM_VC-1:0] r0_to_r1_lck;

    // And back again
    flit_t             r1_to_r0_data;
    logic              r1_to_r0_valid;
    logic              r1_to_r0_vch;
    logic [NUM_VC-1:0] r1_to_r0_ack;
    logic [NUM_VC-1:0] r1_to_r0_lck;

    // Router 0 has no west neighbor
    mesh_router #(.MY_X(2'd0), .MY_Y(2'd0), .BUF_DEPTH(BUF_DEPTH)) u_rtr0 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_data_west   ('0),
        .i_valid_west  (1'b0),
        .i_vch_west    (1'b0),
        .i_ack_west    ('0),
        .i_lck_west    ('0),
        .o_data_west   (),
        .o_valid_west  (),
        .o_vch_west    (),
        .o_ack_west    (),
        .o_lck_west    (),
        .o_rdy_west    (),
        .i_data_east   (r1_to_r0_data),
        .i_valid_east  (r1_to_r0_valid),
        .i_vch_east    (r1_to_r0_vch),
        .i_ack_east    (r1_to_r0_ack),
        .i_lck_east    (r1_to_r0_lck),
        .o_data_east   (r0_to_r1_data),
        .o_valid_east  (r0_to_r1_valid),
        .o_vch_east    (r0_to_r1_vch),
        .o_ack_east    (r0_to_r1_ack),
        .o_lck_east    (r0_to_r1_lck),
        .o_rdy_east    (),
        .i_data_local  (i_data_0),
        .i_valid_local (i_valid_0),
        .i_vch_local   (i_vch_0),
        .i_ack_local   (i_ack_0),
        .i_lck_local   (i_lck_0),
        .o_data_local  (o_data_0),
        .o_valid_local (o_valid_0),
        .o_vch_local   (o_vch_0),
        .o_ack_local   (o_ack_0),
        .o_lck_local   (o_lck_0),
        .o_rdy_local   (o_rdy_0)
    );

    // Router 1 has no east neighbor
    mesh_router #(.MY_X(2'd1), .MY_Y(2'd0), .BUF_DEPTH(BUF_DEPTH)) u_rtr1 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_data_west   (r0_to_r1_data),
        .i_valid_west  (r0_to_r1_valid),
        .i_vch_west    (r0_to_r1_vch),
        .i_ack_west    (r0_to_r1_ack),
        .i_lck_west    (r0_to_r1_lck),
        .o_data_west   (r1_to_r0_data),
        .o_valid_west  (r1_to_r0_valid),
        .o_vch_west    (r1_to_r0_vch),
        .o_ack_west    (r1_to_r0_ack),
        .o_lck_west    (r1_to_r0_lck),
        .o_rdy_west    (),
        .i_data_east   ('0),
        .i_valid_east  (1'b0),
        .i_vch_east    (1'b0),
        .i_ack_east    ('0),
        .i_lck_east    ('0),
        .o_data_east   (),
        .o_valid_east  (),
        .o_vch_east    (),
        .o_ack_east    (),
        .o_lck_east    (),
        .o_rdy_east    (),
        .i_data_local  (i_data_1),
        .i_valid_local (i_valid_1),
        .i_vch_local   (i_vch_1),
        .i_ack_local   (i_ack_1),
        .i_lck_local   (i_lck_1),
        .o_data_local  (o_data_1),
        .o_valid_local (o_valid_1),
        .o_vch_local   (o_vch_1),
        .o_ack_local   (o_ack_1),
        .o_lck_local   (o_lck_1),
        .o_rdy_local   (o_rdy_1)
    );

endmodule

// ==== rtl/noc_pkg.sv ====
package noc_pkg;

    localparam int FLIT_W    = 35;
    localparam int NUM_VC    = 2;
    localparam int NUM_PORTS = 3;

    // Port indices inside a router
    localparam int PORT_WEST  = 0;
    localparam int PORT_EAST  = 1;
    localparam int PORT_LOCAL = 2;

    // Top two bits of every flit
    typedef enum logic [1:0] {
        KIND_BODY   = 2'b00,
        KIND_HEAD   = 2'b01,
        KIND_TAIL   = 2'b10,
        KIND_SINGLE = 2'b11
    } flit_kind_t;

    typedef struct packed {
        flit_kind_t  kind;
        logic [1:0]  dst_x;
        logic [1:0]  dst_y;
        logic [28:0] payload;
    } head_flit_t;

    typedef struct packed {
        flit_kind_t  kind;
        logic [32:0] payload;
    } body_flit_t;

    // Same word, read by kind as a head or as plain data
    typedef union packed {
        head_flit_t head;
        body_flit_t body;
    } flit_t;

    function automatic logic is_head(flit_kind_t kind);
        return (kind == KIND_HEAD) || (kind == KIND_SINGLE);
    endfunction

    function automatic logic is_tail(flit_kind_t kind);
        return (kind == KIND_TAIL) || (kind == KIND_SINGLE);
    endfunction

endpackage

// ==== rtl/output_allocator.sv ====
`timescale 1ns/10ps

module output_allocator (
    input  logic                                          i_clk,
    input  logic                                          i_rst,
    input  logic [noc_pkg::NUM_PORTS*noc_pkg::NUM_VC-1:0] i_req,
    input  logic [noc_pkg::NUM_PORTS*noc_pkg::NUM_VC-1:0] i_req_head,
    input  logic [noc_pkg::NUM_PORTS*noc_pkg::NUM_VC-1:0] i_req_tail,
    input  logic [noc_pkg::NUM_VC-1:0]                    i_has_credit,
    input  logic [noc_pkg::NUM_VC-1:0]                    i_lck,
    output logic [noc_pkg::NUM_PORTS*noc_pkg::NUM_VC-1:0] o_grant
);
    import noc_pkg::*;

    // Requester r is input port r / NUM_VC on VC r % NUM_VC
    localparam int NUM_REQ = NUM_PORTS * NUM_VC;
    localparam int REQ_W   = $clog2(NUM_REQ);
    localparam int VC_W    = $clog2(NUM_VC);

    typedef enum logic {
        VC_IDLE,
        VC_LOCKED
    } vc_state_t;

    vc_state_t          state [NUM_VC];
    logic [REQ_W-1:0]   owner [NUM_VC];
    logic [REQ_W-1:0]   rr_ptr;
    logic [REQ_W-1:0]   win_idx;
    logic [VC_W-1:0]    win_vc;
    logic               win_any;
    logic [NUM_REQ-1:0] elig;

    always_comb begin
        for (int r = 0; r < NUM_REQ; r++) begin
            elig[r] = i_req[r] && i_has_credit[r % NUM_VC] &&
                      ((state[r % NUM_VC] == VC_IDLE && i_req_head[r] && !i_lck[r % NUM_VC]) ||
                       (state[r % NUM_VC] == VC_LOCKED && owner[r % NUM_VC] == REQ_W'(r)));
        end
    end

    // Round robin search from the slot after the last winner
    always_comb begin
        int idx;
        o_grant = '0;
        win_any = 1'b0;
        win_idx = '0;
        for (int k = 0; k < NUM_REQ; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_REQ;
            if (!win_any && elig[idx]) begin
                win_any = 1'b1;
                win_idx = REQ_W'(idx);
            end
        end
        if (win_any) begin
            o_grant[win_idx] = 1'b1;
        end
    end

    // VC count is a power of two, so the low bits give the VC
    assign win_vc = win_idx[VC_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rr_ptr <= '0;
            for (int v = 0; v < NUM_VC; v++) begin
                state[v] <= VC_IDLE;
                owner[v] <= '0;
            end
        end else if (win_any) begin
            rr_ptr <= (int'(win_idx) == NUM_REQ - 1) ? '0 : win_idx + 1'b1;
            if (i_req_tail[win_idx]) begin
                state[win_vc] <= VC_IDLE;
            end else if (i_req_head[win_idx]) begin
                state[win_vc] <= VC_LOCKED;
                owner[win_vc] <= win_idx;
            end
        end
    end

    // A locked VC sees only body or tail flits from its owner
    for (genvar v = 0; v < NUM_VC; v++) begin : g_chk
        a_owner_no_head: assert property (@(posedge i_clk) disable iff (i_rst)
            state[v] == VC_LOCKED && i_req[owner[v]] |-> !i_req_head[owner[v]]);
    end

endmodule

// ==== rtl/vc_input_buffer.sv ====
`timescale 1ns/10ps

module vc_input_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst,
    input  noc_pkg::flit_t                         i_data,
    input  logic                                   i_valid,
    input  logic                                   i_vch,
    input  logic [noc_pkg::NUM_VC-1:0]             i_deq,
    output noc_pkg::flit_t [noc_pkg::NUM_VC-1:0]   o_head_data,
    output logic [noc_pkg::NUM_VC-1:0]             o_head_valid,
    output logic [noc_pkg::NUM_VC-1:0]             o_ack,
    output logic [noc_pkg::NUM_VC-1:0]             o_rdy,
    output logic [noc_pkg::NUM_VC-1:0]             o_lck
);
    import noc_pkg::*;

    localparam int PTR_W = $clog2(BUF_DEPTH);

    for (genvar v = 0; v < NUM_VC; v++) begin : g_vc
        flit_t            mem [BUF_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W:0]   count;
        logic             wr_en;

        assign wr_en = i_valid && (i_vch == 1'(v));

        always_ff @(posedge i_clk) begin
            if (wr_en) begin
                mem[wr_ptr] <= i_data;
            end
        end

        // Pointers wrap on their own since the depth is a power of two
        always_ff @(posedge i_clk) begin
            if (i_rst) begin
                wr_ptr   <= '0;
                rd_ptr   <= '0;
                count    <= '0;
                o_lck[v] <= 1'b0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (i_deq[v]) begin
                    rd_ptr <= rd_ptr + 1'b1;
                    // Single flits open and close in one pop
                    if (is_tail(o_head_data[v].head.kind)) begin
                        o_lck[v] <= 1'b0;
                    end else if (is_head(o_head_data[v].head.kind)) begin
                        o_lck[v] <= 1'b1;
                    end
                end
                count <= count + {{PTR_W{1'b0}}, wr_en} - {{PTR_W{1'b0}}, i_deq[v]};
            end
        end

        assign o_head_data[v]  = mem[rd_ptr];
        assign o_head_valid[v] = (count != '0);
        assign o_rdy[v]        = (count != (PTR_W+1)'(BUF_DEPTH));
        // Every pop hands one credit back upstream
        assign o_ack[v]        = i_deq[v];

        // Upstream credits must keep the FIFO from overflowing
        a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
            wr_en |-> o_rdy[v]);

        a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
            i_deq[v] |-> o_head_valid[v]);
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mesh_row_tb \
    -f files.f \
    -o mesh_row_sim

out="$(./obj_dir/mesh_row_sim)"
echo "$out"

if grep -qx "TESTBENCH PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== sim/mesh_row_tb.sv ====
`timescale 1ns/10ps

module mesh_row_tb;
    import noc_pkg::*;

    localparam int BUF_DEPTH  = 4;
    localparam int MAX_CYCLES = 3000;

    logic              clk;
    logic              rst;
    logic [FLIT_W-1:0] in_data   [2];
    logic              in_valid  [2];
    logic              in_vch    [2];
    logic [NUM_VC-1:0] in_ack    [2];
    logic [NUM_VC-1:0] in_lck    [2];
    flit_t             out_data  [2];
    logic              out_valid [2];
    logic              out_vch   [2];
    logic [NUM_VC-1:0] out_ack   [2];
    logic [NUM_VC-1:0] out_lck   [2];
    logic [NUM_VC-1:0] out_rdy   [2];
    logic [NUM_VC-1:0] lck_q     [2];

    // Queues are indexed by port * 2 + vc; tx entries are {dst, flit}
    logic [FLIT_W:0]   tx_q  [4][$];
    logic [FLIT_W-1:0] exp_q [4][$];
    int                sent [4];
    int                acked [4];
    int                rx_cnt [4];
    int                ack_given [4];
    int                rx_at_stall [4];
    logic              stall [4];
    logic              in_pkt [4];
    int                rr [2];
    int                errors;
    int                tests_run;
    int                cycles;
    logic [31:0]       lfsr;

    mesh_row #(.BUF_DEPTH(BUF_DEPTH)) DUT (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_data_0  (in_data[0]),
        .i_valid_0 (in_valid[0]),
        .i_vch_0   (in_vch[0]),
        .i_ack_0   (in_ack[0]),
        .i_lck_0   (in_lck[0]),
        .o_data_0  (out_data[0]),
        .o_valid_0 (out_valid[0]),
        .o_vch_0   (out_vch[0]),
        .o_ack_0   (out_ack[0]),
        .o_lck_0   (out_lck[0]),
        .o_rdy_0   (out_rdy[0]),
        .i_data_1  (in_data[1]),
        .i_valid_1 (in_valid[1]),
        .i_vch_1   (in_vch[1]),
        .i_ack_1   (in_ack[1]),
        .i_lck_1   (in_lck[1]),
        .o_data_1  (out_data[1]),
        .o_valid_1 (out_valid[1]),
        .o_vch_1   (out_vch[1]),
        .o_ack_1   (out_ack[1]),
        .o_lck_1   (out_lck[1]),
        .o_rdy_1   (out_rdy[1])
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [32:0] take_bits(int n);
        logic [32:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[31:0], lfsr[0]};
        end
        return bits;
    endfunction

    task automatic queue_packet(input int src, input int dst, input int vc, input int len);
        flit_t f;
        for (int i = 0; i < len; i++) begin
            if (i == 0) begin
                f.head.kind    = (len == 1) ? KIND_SINGLE : KIND_HEAD;
                f.head.dst_x   = 2'(dst);
                f.head.dst_y   = 2'd0;
                f.head.payload = 29'(take_bits(29));
            end else begin
                f.body.kind    = (i == len - 1) ? KIND_TAIL : KIND_BODY;
                f.body.payload = take_bits(33);
            end
            tx_q[src*2+vc].push_back({1'(dst), f});
        end
    endtask

    // Sources alternate VCs and send only with credit in hand
    task automatic drive_sources();
        int v;
        int q;
        logic [FLIT_W:0] entry;
        for (int s = 0; s < 2; s++) begin
            in_valid[s] = 1'b0;
            for (int k = 0; k < 2 && !rst; k++) begin
                v = (rr[s] + k) % 2;
                q = s * 2 + v;
                if (!in_valid[s] && tx_q[q].size() > 0 &&
                        BUF_DEPTH - sent[q] + acked[q] > 0) begin
                    entry = tx_q[q].pop_front();
                    in_data[s]  = entry[FLIT_W-1:0];
                    in_vch[s]   = 1'(v);
                    in_valid[s] = 1'b1;
                    exp_q[int'(entry[FLIT_W])*2+v].push_back(entry[FLIT_W-1:0]);
                    sent[q]++;
                    rr[s] = 1 - v;
                end
            end
        end
    endtask

    task automatic drive_acks();
        for (int d = 0; d < 2; d++) begin
            in_ack[d] = '0;
            for (int v = 0; v < 2; v++) begin
                if (!stall[d*2+v] && ack_given[d*2+v] < rx_cnt[d*2+v]) begin
                    in_ack[d][v] = 1'b1;
                    ack_given[d*2+v]++;
                end
            end
        end
    endtask

    initial begin
        for (int s = 0; s < 2; s++) begin
            in_data[s]  = '0;
            in_valid[s] = 1'b0;
            in_vch[s]   = 1'b0;
            in_ack[s]   = '0;
        end
        forever begin
            @(posedge clk);
            #1;
            drive_sources();
            drive_acks();
        end
    end

    task automatic check_flit(input int d);
        int    i;
        flit_t got;
        flit_t exp;
        got = out_data[d];
        i   = d * 2 + int'(out_vch[d]);
        rx_cnt[i]++;
        if (exp_q[i].size() == 0) begin
            errors++;
            $display("%0t: flit arrived at local port %0d VC %0d with none outstanding",
                     $time, d, i % 2);
        end else begin
            exp = exp_q[i].pop_front();
            a_data: assert (got == exp) else begin
                errors++;
                $display("[ERROR] %0t o_data_%0d: got %h expected %h", $time, d, got, exp);
            end
        end
        // Head only outside a packet, body and tail only inside one
        a_contig: assert (is_head(got.head.kind) == !in_pkt[i]) else begin
            errors++;
            $display("[ERROR] %0t o_data_%0d kind: got %0d expected %s", $time, d,
                     got.head.kind, in_pkt[i] ? "body or tail" : "head");
        end
        if (is_tail(got.head.kind)) begin
            in_pkt[i] = 1'b0;
        end else if (is_head(got.head.kind)) begin
            in_pkt[i] = 1'b1;
        end
        if (stall[i]) begin
            a_stall_bound: assert (rx_cnt[i] - rx_at_stall[i] <= BUF_DEPTH) else begin
                errors++;
                $display("[ERROR] %0t o_valid_%0d count while stalled: got %0d limit %0d",
                         $time, d, rx_cnt[i] - rx_at_stall[i], BUF_DEPTH);
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int s = 0; s < 2; s++) begin
                for (int v = 0; v < 2; v++) begin
                    if (out_ack[s][v]) begin
                        acked[s*2+v]++;
                    end
                end
                if (out_valid[s]) begin
                    check_flit(s);
                end
            end
        end
    end

    always @(posedge clk) begin
        lck_q[0] <= in_lck[0];
        lck_q[1] <= in_lck[1];
    end

    for (genvar d = 0; d < 2; d++) begin : g_chk
        a_no_head_when_locked: assert property (@(posedge clk) disable iff (rst)
            out_valid[d] && is_head(out_data[d].head.kind) |-> !lck_q[d][out_vch[d]])
        else begin
            errors++;
            $display("[ERROR] %0t o_vch_%0d: head on locked VC %0d, expected no head",
                     $time, d, out_vch[d]);
        end
    end

    task automatic check_idle(input int d);
        a_idle: assert (!out_valid[d] && out_ack[d] == '0 && out_lck[d] == '0 &&
                        out_rdy[d] == 2'b11)
        else begin
            errors++;
            $display("[ERROR] %0t o_valid/o_ack/o_lck/o_rdy_%0d: got %b/%b/%b/%b %s",
                     $time, d, out_valid[d], out_ack[d], out_lck[d], out_rdy[d],
                     "expected 0/00/00/11");
        end
    endtask

    task automatic wait_drain();
        int busy;
        busy = 1;
        while (busy != 0) begin
            @(posedge clk);
            busy = 0;
            for (int i = 0; i < 4; i++) begin
                if (tx_q[i].size() != 0 || exp_q[i].size() != 0 || ack_given[i] != rx_cnt[i]) begin
                    busy = 1;
                end
            end
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        $display("test %0d %s: done, %0d errors", tests_run, name, errors - errs_before);
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run took more than %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int e;
        int base2;
        int base3;
        rst       = 1'b1;
        errors    = 0;
        tests_run = 0;
        lfsr      = 32'hd5d7_e8ff;
        in_lck[0] = '0;
        in_lck[1] = '0;
        rr[0]     = 0;
        rr[1]     = 0;
        for (int i = 0; i < 4; i++) begin
            stall[i]  = 1'b0;
            in_pkt[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        e = errors;
        @(negedge clk);
        check_idle(0);
        check_idle(1);
        report_test("reset state", e);

        // Cross traffic first, then loopback, so each queue has one source
        e = errors;
        @(posedge clk);
        #1;
        for (int v = 0; v < 2; v++) begin
            queue_packet(0, 1, v, 1);
            queue_packet(1, 0, v, 1);
        end
        wait_drain();
        for (int v = 0; v < 2; v++) begin
            queue_packet(0, 0, v, 1);
            queue_packet(1, 1, v, 1);
        end
        wait_drain();
        report_test("single flits", e);

        e = errors;
        for (int n = 0; n < 3; n++) begin
            for (int v = 0; v < 2; v++) begin
                queue_packet(0, 1, v, int'(take_bits(2)) + 1);
                queue_packet(1, 0, v, int'(take_bits(2)) + 1);
            end
        end
        wait_drain();
        report_test("multi-flit both VCs", e);

        // Sink 1 holds back credits on VC 0
        e = errors;
        rx_at_stall[2] = rx_cnt[2];
        stall[2] = 1'b1;
        for (int n = 0; n < 3; n++) begin
            queue_packet(0, 1, 0, 4);
        end
        queue_packet(0, 1, 1, 3);
        queue_packet(0, 1, 1, 2);
        repeat (80) @(posedge clk);
        #1 stall[2] = 1'b0;
        wait_drain();
        for (int q = 0; q < 4; q++) begin
            a_ack_count: assert (acked[q] == sent[q]) else begin
                errors++;
                $display("[ERROR] %0t o_ack_%0d[%0d] pulses: got %0d expected %0d",
                         $time, q / 2, q % 2, acked[q], sent[q]);
            end
        end
        report_test("ack stall", e);

        // Sink 1 locks VC 1 once the first packet has started
        e = errors;
        base2 = rx_cnt[2];
        base3 = rx_cnt[3];
        queue_packet(0, 1, 1, 7);
        queue_packet(0, 1, 1, 3);
        queue_packet(0, 1, 0, 4);
        queue_packet(0, 1, 0, 4);
        while (rx_cnt[3] == base3) @(posedge clk);
        #1 in_lck[1] = 2'b10;
        while (rx_cnt[3] < base3 + 7) @(posedge clk);
        repeat (40) @(posedge clk);
        a_lock_held: assert (rx_cnt[3] == base3 + 7) else begin
            errors++;
            $display("%0t: a new packet got through on locked VC 1", $time);
        end
        a_other_vc: assert (rx_cnt[2] == base2 + 8) else begin
            errors++;
            $display("%0t: VC 0 stopped delivering while VC 1 was locked", $time);
        end
        #1 in_lck[1] = 2'b00;
        wait_drain();
        report_test("VC lock", e);

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
